// ==== Makefile ====
TOP = core_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --assert --timing -j 0 --top-module $(TOP) -f core.f -o sim
	@out=$$(./obj_dir/sim); echo "$$out"; echo "$$out" | grep -qx "all tests passed"

lint:
	verilator --lint-only --assert --timing --top-module $(TOP) -f core.f
	verilator --lint-only --assert --top-module core hdl/core_pkg.sv hdl/isa_pkg.sv \
		hdl/alu.sv hdl/regfile.sv hdl/decoder.sv hdl/hazard_unit.sv hdl/fetch_stage.sv hdl/core.sv

clean:
	rm -rf obj_dir

// ==== core.f ====
hdl/core_pkg.sv
hdl/isa_pkg.sv
hdl/alu.sv
hdl/regfile.sv
hdl/decoder.sv
hdl/hazard_unit.sv
hdl/fetch_stage.sv
hdl/core.sv
verif/core_tb.sv

// ==== hdl/alu.sv ====
`timescale 1ns/1ps

module alu (
	input  core_pkg::u64      a,
	input  core_pkg::u64      b,
	input  core_pkg::alu_op_t op,
	output core_pkg::u64      y
);
	logic [5:0] shamt;

	assign shamt = b[5:0];

	always_comb begin
		case (op)
			core_pkg::alu_add:    y = a + b;
			core_pkg::alu_sub:    y = a - b;
			core_pkg::alu_and:    y = a & b;
			core_pkg::alu_or:     y = a | b;
			core_pkg::alu_xor:    y = a ^ b;
			core_pkg::alu_slt:    y = {63'b0, $signed(a) < $signed(b)};
			core_pkg::alu_sltu:   y = {63'b0, a < b};
			core_pkg::alu_sll:    y = a << shamt;
			core_pkg::alu_srl:    y = a >> shamt;
			core_pkg::alu_sra:    y = $signed(a) >>> shamt;
			core_pkg::alu_pass_b: y = b;
			default:              y = '0;
		endcase
	end

endmodule

// ==== hdl/core.sv ====
`timescale 1ns/1ps

module core #(
	parameter core_pkg::u64 reset_pc = '0
) (
	input  logic         clk,
	input  logic         rst,
	output logic         ireq_valid,
	output core_pkg::u64 ireq_addr,
	input  logic         iresp_data_ok,
	input  core_pkg::u32 iresp_data,
	output logic         dreq_valid,
	output logic         dreq_write,
	output core_pkg::u64 dreq_addr,
	output core_pkg::u64 dreq_wdata,
	input  logic         dresp_data_ok,
	input  core_pkg::u64 dresp_rdata
);
	logic               id_valid, load_use_stall, mem_stall, redirect;
	core_pkg::u64       id_pc, redirect_pc, id_a, id_b;
	core_pkg::u32       id_instr;
	core_pkg::reg_idx_t dec_rs1, dec_rs2, dec_rd;
	core_pkg::u64       dec_imm;
	core_pkg::alu_op_t  dec_alu_op;
	logic               dec_alu_src_imm, dec_uses_rs1, dec_uses_rs2;
	logic               dec_reg_write, dec_mem_read, dec_mem_write;
	core_pkg::branch_t  dec_branch;

	core_pkg::u64       ex_pc, ex_imm, ex_a, ex_b;  // ID/EX
	core_pkg::reg_idx_t ex_rs1, ex_rs2, ex_rd;
	core_pkg::alu_op_t  ex_alu_op;
	logic               ex_alu_src_imm, ex_reg_write, ex_mem_read, ex_mem_write;
	core_pkg::branch_t  ex_branch;
	core_pkg::fwd_sel_t fwd_a, fwd_b;
	core_pkg::u64       op_a, op_b, alu_y, ex_result;

	core_pkg::u64       mem_pc, mem_imm, mem_result, mem_a, mem_b;  // EX/MEM
	core_pkg::reg_idx_t mem_rd;
	logic               mem_reg_write, mem_mem_read, mem_mem_write;
	core_pkg::branch_t  mem_branch;

	core_pkg::u64       wb_result, wb_load, wb_data;  // MEM/WB
	core_pkg::reg_idx_t wb_rd;
	logic               wb_reg_write, wb_mem_read;

	function automatic core_pkg::u64 fwd_mux(core_pkg::fwd_sel_t sel, core_pkg::u64 reg_val,
			core_pkg::u64 ex_mem_val, core_pkg::u64 wb_val);
		case (sel)
			core_pkg::fwd_ex_mem: fwd_mux = ex_mem_val;
			core_pkg::fwd_wb:     fwd_mux = wb_val;
			default:              fwd_mux = reg_val;
		endcase
	endfunction

	fetch_stage #(.reset_pc(reset_pc)) u_fetch (
		.clk, .rst,
		.hold(load_use_stall || mem_stall),
		.redirect, .redirect_pc,
		.iresp_data_ok, .iresp_data,
		.ireq_valid, .ireq_addr,
		.id_valid, .id_pc, .id_instr
	);

	decoder u_decoder (
		.instr(id_instr),
		.rs1(dec_rs1), .rs2(dec_rs2), .rd(dec_rd), .imm(dec_imm),
		.alu_op(dec_alu_op), .alu_src_imm(dec_alu_src_imm),
		.uses_rs1(dec_uses_rs1), .uses_rs2(dec_uses_rs2),
		.reg_write(dec_reg_write), .mem_read(dec_mem_read), .mem_write(dec_mem_write),
		.branch(dec_branch)
	);

	regfile u_regfile (
		.clk, .rst,
		.ra1(dec_rs1), .ra2(dec_rs2),
		.we(wb_reg_write), .wa(wb_rd), .wd(wb_data),
		.rd1(id_a), .rd2(id_b)
	);

	hazard_unit u_hazard (
		.id_rs1(dec_rs1), .id_rs2(dec_rs2),
		.id_uses_rs1(dec_uses_rs1 && id_valid), .id_uses_rs2(dec_uses_rs2 && id_valid),
		.ex_rd, .ex_rs1, .ex_rs2, .ex_mem_read,
		.mem_rd, .mem_reg_write,
		.wb_rd, .wb_reg_write,
		.load_use_stall, .fwd_a, .fwd_b
	);

	always_ff @(posedge clk) begin
		if (rst || (!mem_stall && (redirect || load_use_stall))) begin
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_branch <= core_pkg::br_none;
		end else if (!mem_stall) begin
			ex_reg_write <= dec_reg_write && id_valid;
			ex_mem_read <= dec_mem_read && id_valid;
			ex_mem_write <= dec_mem_write && id_valid;
			ex_branch <= id_valid ? dec_branch : core_pkg::br_none;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_stall) begin
			ex_a <= op_a;  // Keep forwarded values once MEM/WB drains
			ex_b <= op_b;
		end else begin
			ex_pc <= id_pc;
			ex_imm <= dec_imm;
			ex_a <= id_a;
			ex_b <= id_b;
			ex_rs1 <= dec_rs1;
			ex_rs2 <= dec_rs2;
			ex_rd <= dec_rd;
			ex_alu_op <= dec_alu_op;
			ex_alu_src_imm <= dec_alu_src_imm;
		end
	end

	assign op_a = fwd_mux(fwd_a, ex_a, mem_result, wb_data);
	assign op_b = fwd_mux(fwd_b, ex_b, mem_result, wb_data);

	alu u_alu (
		.a(op_a),
		.b(ex_alu_src_imm ? ex_imm : op_b),
		.op(ex_alu_op),
		.y(alu_y)
	);

	assign ex_result = (ex_branch == core_pkg::br_jal) ? ex_pc + 64'd4 : alu_y;

	always_ff @(posedge clk) begin
		if (rst || (!mem_stall && redirect)) begin
			mem_reg_write <= 1'b0;
			mem_mem_read <= 1'b0;
			mem_mem_write <= 1'b0;
			mem_branch <= core_pkg::br_none;
		end else if (!mem_stall) begin
			mem_reg_write <= ex_reg_write;
			mem_mem_read <= ex_mem_read;
			mem_mem_write <= ex_mem_write;
			mem_branch <= ex_branch;
		end
	end

	always_ff @(posedge clk) begin
		if (!mem_stall) begin
			mem_pc <= ex_pc;
			mem_imm <= ex_imm;
			mem_result <= ex_result;
			mem_a <= op_a;
			mem_b <= op_b;
			mem_rd <= ex_rd;
		end
	end

	always_comb begin
		case (mem_branch)
			core_pkg::br_beq: redirect = mem_a == mem_b;
			core_pkg::br_bne: redirect = mem_a != mem_b;
			core_pkg::br_blt: redirect = $signed(mem_a) < $signed(mem_b);
			core_pkg::br_bge: redirect = $signed(mem_a) >= $signed(mem_b);
			core_pkg::br_jal: redirect = 1'b1;
			default:          redirect = 1'b0;
		endcase
	end

	assign redirect_pc = mem_pc + mem_imm;

	assign dreq_valid = mem_mem_read || mem_mem_write;
	assign dreq_write = mem_mem_write;
	assign dreq_addr = mem_result;
	assign dreq_wdata = mem_b;
	assign mem_stall = dreq_valid && !dresp_data_ok;

	always_ff @(posedge clk) begin
		if (rst || mem_stall)
			wb_reg_write <= 1'b0;  // Bubble while the bus waits
		else
			wb_reg_write <= mem_reg_write;
	end

	always_ff @(posedge clk) begin
		wb_rd <= mem_rd;
		wb_result <= mem_result;
		wb_load <= dresp_rdata;
		wb_mem_read <= mem_mem_read;
	end

	assign wb_data = wb_mem_read ? wb_load : wb_result;

	assert property (@(posedge clk) disable iff (rst)
		dreq_valid && !dresp_data_ok |=> dreq_valid && $stable(dreq_write)
			&& $stable(dreq_addr) && $stable(dreq_wdata));

endmodule

// ==== hdl/core_pkg.sv ====
package core_pkg;

	typedef logic [63:0] u64;  // Data, addresses, immediates
	typedef logic [31:0] u32;  // Instruction word
	typedef logic [4:0]  reg_idx_t;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_pass_b  // lui
	} alu_op_t;

	typedef enum logic [2:0] {
		br_none,
		br_beq,
		br_bne,
		br_blt,
		br_bge,
		br_jal
	} branch_t;

	// Operand source for execute
	typedef enum logic [1:0] {
		fwd_reg,
		fwd_ex_mem,
		fwd_wb
	} fwd_sel_t;

endpackage

// ==== hdl/decoder.sv ====
`timescale 1ns/1ps

module decoder (
	input  core_pkg::u32       instr,
	output core_pkg::reg_idx_t rs1,
	output core_pkg::reg_idx_t rs2,
	output core_pkg::reg_idx_t rd,
	output core_pkg::u64       imm,
	output core_pkg::alu_op_t  alu_op,
	output logic               alu_src_imm,
	output logic               uses_rs1,
	output logic               uses_rs2,
	output logic               reg_write,
	output logic               mem_read,
	output logic               mem_write,
	output core_pkg::branch_t  branch
);
	logic [6:0]   opcode;
	logic [2:0]   funct3;
	logic         reg_alt;
	logic         imm_alt;
	core_pkg::u64 imm_i, imm_s, imm_b, imm_u, imm_j;

	function automatic core_pkg::alu_op_t alu_fn(logic [2:0] f3, logic alt);
		case (f3)
			isa_pkg::f3_add_sub: alu_fn = alt ? core_pkg::alu_sub : core_pkg::alu_add;
			isa_pkg::f3_sll:     alu_fn = core_pkg::alu_sll;
			isa_pkg::f3_slt:     alu_fn = core_pkg::alu_slt;
			isa_pkg::f3_sltu:    alu_fn = core_pkg::alu_sltu;
			isa_pkg::f3_xor:     alu_fn = core_pkg::alu_xor;
			isa_pkg::f3_srl_sra: alu_fn = alt ? core_pkg::alu_sra : core_pkg::alu_srl;
			isa_pkg::f3_or:      alu_fn = core_pkg::alu_or;
			default:             alu_fn = core_pkg::alu_and;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];

	assign reg_alt = instr[31:25] == isa_pkg::funct7_alt;
	// srai keeps the alt bit in funct6, shamt takes bit 25
	assign imm_alt = funct3 == isa_pkg::f3_srl_sra && instr[31:26] == isa_pkg::funct7_alt[6:1];

	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
	assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm = '0;
		alu_op = core_pkg::alu_add;
		alu_src_imm = 1'b0;
		uses_rs1 = 1'b0;
		uses_rs2 = 1'b0;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = core_pkg::br_none;
		case (opcode)
			isa_pkg::op_reg: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				reg_write = 1'b1;
				alu_op = alu_fn(funct3, reg_alt);
			end
			isa_pkg::op_imm: begin
				uses_rs1 = 1'b1;
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				imm = imm_i;
				alu_op = alu_fn(funct3, imm_alt);
			end
			isa_pkg::op_lui: begin
				reg_write = 1'b1;
				alu_src_imm = 1'b1;
				imm = imm_u;
				alu_op = core_pkg::alu_pass_b;
			end
			isa_pkg::op_load: begin
				uses_rs1 = 1'b1;
				reg_write = 1'b1;
				mem_read = 1'b1;
				alu_src_imm = 1'b1;
				imm = imm_i;
			end
			isa_pkg::op_store: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				mem_write = 1'b1;
				alu_src_imm = 1'b1;
				imm = imm_s;
			end
			isa_pkg::op_branch: begin
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				imm = imm_b;
				case (funct3)
					isa_pkg::f3_beq: branch = core_pkg::br_beq;
					isa_pkg::f3_bne: branch = core_pkg::br_bne;
					isa_pkg::f3_blt: branch = core_pkg::br_blt;
					isa_pkg::f3_bge: branch = core_pkg::br_bge;
					default:         branch = core_pkg::br_none;
				endcase
			end
			isa_pkg::op_jal: begin
				reg_write = 1'b1;  // Link value comes from execute
				imm = imm_j;
				branch = core_pkg::br_jal;
			end
			default: ;  // Treated as nop
		endcase
	end

endmodule

// ==== hdl/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage #(
	parameter core_pkg::u64 reset_pc = '0
) (
	input  logic         clk,
	input  logic         rst,
	input  logic         hold,
	input  logic         redirect,
	input  core_pkg::u64 redirect_pc,
	input  logic         iresp_data_ok,
	input  core_pkg::u32 iresp_data,
	output logic         ireq_valid,
	output core_pkg::u64 ireq_addr,
	output logic         id_valid,
	output core_pkg::u64 id_pc,
	output core_pkg::u32 id_instr
);
	core_pkg::u64 pc;
	core_pkg::u64 pend_pc;
	logic         pend;  // Redirect arrived while a fetch was in flight
	logic         fetch_done;
	logic         take;

	assign ireq_addr = pc;
	assign fetch_done = ireq_valid && iresp_data_ok;
	assign take = fetch_done && !pend && !redirect && !hold;

	always_ff @(posedge clk) begin
		if (rst) begin
			ireq_valid <= 1'b0;
			pc <= reset_pc;
			pend <= 1'b0;
		end else begin
			ireq_valid <= 1'b1;
			if (redirect) begin
				if (fetch_done) begin
					pc <= redirect_pc;
					pend <= 1'b0;
				end else begin
					pend <= 1'b1;  // Address must stay put until the word returns
				end
			end else if (fetch_done && pend) begin
				pc <= pend_pc;  // Stale word dropped
				pend <= 1'b0;
			end else if (take) begin
				pc <= pc + 64'd4;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (redirect)
			pend_pc <= redirect_pc;
	end

	// IF/ID
	always_ff @(posedge clk) begin
		if (rst || redirect) begin
			id_valid <= 1'b0;
			id_instr <= isa_pkg::nop_instr;
		end else if (!hold) begin
			id_valid <= take;
			id_instr <= take ? iresp_data : isa_pkg::nop_instr;
		end
	end

	always_ff @(posedge clk) begin
		if (take)
			id_pc <= pc;
	end

	assert property (@(posedge clk) disable iff (rst)
		ireq_valid && !iresp_data_ok |=> ireq_valid && $stable(ireq_addr));

endmodule

// ==== hdl/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit (
	input  core_pkg::reg_idx_t id_rs1,
	input  core_pkg::reg_idx_t id_rs2,
	input  logic               id_uses_rs1,
	input  logic               id_uses_rs2,
	input  core_pkg::reg_idx_t ex_rd,
	input  core_pkg::reg_idx_t ex_rs1,
	input  core_pkg::reg_idx_t ex_rs2,
	input  logic               ex_mem_read,
	input  core_pkg::reg_idx_t mem_rd,
	input  logic               mem_reg_write,
	input  core_pkg::reg_idx_t wb_rd,
	input  logic               wb_reg_write,
	output logic               load_use_stall,
	output core_pkg::fwd_sel_t fwd_a,
	output core_pkg::fwd_sel_t fwd_b
);
	// Newest producer wins
	function automatic core_pkg::fwd_sel_t pick(core_pkg::reg_idx_t src,
			core_pkg::reg_idx_t m_rd, logic m_we, core_pkg::reg_idx_t w_rd, logic w_we);
		if (m_we && m_rd != '0 && m_rd == src)
			return core_pkg::fwd_ex_mem;
		if (w_we && w_rd != '0 && w_rd == src)
			return core_pkg::fwd_wb;
		return core_pkg::fwd_reg;
	endfunction

	assign fwd_a = pick(ex_rs1, mem_rd, mem_reg_write, wb_rd, wb_reg_write);
	assign fwd_b = pick(ex_rs2, mem_rd, mem_reg_write, wb_rd, wb_reg_write);

	assign load_use_stall = ex_mem_read && ex_rd != '0 &&
		((id_uses_rs1 && id_rs1 == ex_rd) || (id_uses_rs2 && id_rs2 == ex_rd));

endmodule

// ==== hdl/isa_pkg.sv ====
package isa_pkg;

	localparam logic [6:0] op_reg    = 7'b0110011;
	localparam logic [6:0] op_imm    = 7'b0010011;
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;

	localparam logic [2:0] f3_add_sub = 3'b000;
	localparam logic [2:0] f3_sll     = 3'b001;
	localparam logic [2:0] f3_slt     = 3'b010;
	localparam logic [2:0] f3_sltu    = 3'b011;
	localparam logic [2:0] f3_xor     = 3'b100;
	localparam logic [2:0] f3_srl_sra = 3'b101;
	localparam logic [2:0] f3_or      = 3'b110;
	localparam logic [2:0] f3_and     = 3'b111;

	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;
	localparam logic [2:0] f3_blt = 3'b100;
	localparam logic [2:0] f3_bge = 3'b101;

	localparam logic [6:0]  funct7_alt = 7'b0100000;  // sub, sra
	localparam logic [31:0] nop_instr  = 32'h0000_0013;  // addi x0,x0,0

endpackage

// ==== hdl/regfile.sv ====
`timescale 1ns/1ps

module regfile (
	input  logic               clk,
	input  logic               rst,
	input  core_pkg::reg_idx_t ra1,
	input  core_pkg::reg_idx_t ra2,
	input  logic               we,
	input  core_pkg::reg_idx_t wa,
	input  core_pkg::u64       wd,
	output core_pkg::u64       rd1,
	output core_pkg::u64       rd2
);
	core_pkg::u64 regs [32];
	logic         wr_en;

	assign wr_en = we && wa != '0;

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (wr_en) begin
			regs[wa] <= wd;
		end
	end

	// Write-through so decode sees this cycle's writeback
	assign rd1 = (wr_en && wa == ra1) ? wd : regs[ra1];
	assign rd2 = (wr_en && wa == ra2) ? wd : regs[ra2];

	assert property (@(posedge clk) disable iff (rst)
		(ra1 == '0 |-> rd1 == '0) and (ra2 == '0 |-> rd2 == '0));

endmodule

// ==== verif/core_tb.sv ====
`timescale 1ns/1ps

module core_tb;

	localparam core_pkg::u64 poison_addr = 64'h300;
	localparam int max_cycles = 3000;  // ~60 fetches at up to 4 cycles, loop and refetch

	logic         clk = 1'b0;
	logic         rst;
	logic         ireq_valid;
	core_pkg::u64 ireq_addr;
	logic         iresp_data_ok;
	core_pkg::u32 iresp_data;
	logic         dreq_valid;
	logic         dreq_write;
	core_pkg::u64 dreq_addr;
	core_pkg::u64 dreq_wdata;
	logic         dresp_data_ok;
	core_pkg::u64 dresp_rdata;

	core_pkg::u32 imem [256];
	core_pkg::u64 dmem [128];
	logic         jump_dst [256];  // Words that some branch or jal may land on
	int           pc_words;
	core_pkg::u64 exp_addr [$];
	core_pkg::u64 exp_data [$];
	string        exp_name [$];
	int           seen, n_ok, n_bad, errors;
	int           cycles = 0;
	logic [31:0]  rng;
	logic [1:0]   i_wait, d_wait;

	core #(.reset_pc(64'd0)) u_core (.*);

	always #2 clk = ~clk;

	always @(posedge clk) cycles <= cycles + 1;

	function automatic logic [31:0] xorshift(logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic core_pkg::u64 fill_word(int idx);
		return {32'h5eed_0000 ^ idx, ~idx};
	endfunction

	task automatic put(core_pkg::u32 w);
		imem[pc_words] = w;
		pc_words++;
	endtask

	task automatic alu_imm(int f3, int rd, int rs1, int imm);
		put({imm[11:0], rs1[4:0], f3[2:0], rd[4:0], 7'h13});
	endtask

	task automatic alu_reg(int f7, int f3, int rd, int rs1, int rs2);
		put({f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33});
	endtask

	task automatic load_upper(int rd, int imm);
		put({imm[19:0], rd[4:0], 7'h37});
	endtask

	task automatic load_dw(int rd, int off);
		put({off[11:0], 5'd0, 3'b011, rd[4:0], 7'h03});
	endtask

	task automatic store_dw(int rs2, int off);
		put({off[11:5], rs2[4:0], 5'd0, 3'b011, off[4:0], 7'h23});
	endtask

	task automatic branch_to(int f3, int rs1, int rs2, int off);
		jump_dst[pc_words + off / 4] = 1'b1;
		put({off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], 7'h63});
	endtask

	task automatic jump_link(int rd, int off);
		jump_dst[pc_words + off / 4] = 1'b1;
		put({off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'h6f});
	endtask

	task automatic expect_store(core_pkg::u64 addr, core_pkg::u64 data, string name);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_name.push_back(name);
	endtask

	task automatic build_program();
		core_pkg::u64 link;
		for (int i = 0; i < 256; i++) begin
			imem[i] = 32'h0000_0013;
			jump_dst[i] = 1'b0;
		end
		for (int i = 0; i < 128; i++)
			dmem[i] = fill_word(i);
		pc_words = 0;
		alu_imm(0, 1, 0, 7);
		alu_imm(0, 2, 0, -3);
		alu_reg(0, 0, 3, 1, 2);   // add, both operands forwarded
		alu_reg(32, 0, 4, 3, 1);  // sub
		alu_reg(0, 4, 5, 4, 3);   // xor
		alu_reg(0, 1, 6, 5, 1);   // sll
		alu_reg(32, 5, 7, 6, 3);  // sra
		alu_reg(0, 2, 8, 7, 2);   // slt
		store_dw(7, 'h100);
		expect_store(64'h100, 64'hffff_ffff_ffff_ffc8, "chain_sra");
		store_dw(8, 'h108);
		expect_store(64'h108, 64'd1, "chain_slt");
		load_upper(9, 'h12345);
		alu_imm(5, 10, 9, 12);    // srli
		store_dw(10, 'h110);
		expect_store(64'h110, 64'h12345, "lui_srli");
		alu_reg(0, 3, 11, 1, 2);  // sltu
		alu_reg(0, 5, 12, 2, 3);  // srl
		alu_reg(0, 4, 13, 12, 11);
		store_dw(13, 'h118);
		expect_store(64'h118, 64'h0fff_ffff_ffff_fffe, "sltu_srl");
		load_dw(14, 'h200);
		alu_imm(0, 15, 14, 5);    // Needs the load result at once
		store_dw(15, 'h120);
		expect_store(64'h120, fill_word('h200 / 8) + 64'd5, "load_use");
		branch_to(0, 1, 1, 12);   // beq taken
		store_dw(1, poison_addr);
		store_dw(1, poison_addr);
		branch_to(4, 2, 1, 12);   // blt taken
		store_dw(1, poison_addr);
		store_dw(1, poison_addr);
		branch_to(1, 1, 1, 8);    // bne falls through
		store_dw(1, 'h128);
		expect_store(64'h128, 64'd7, "bne_fall");
		branch_to(5, 2, 1, 8);    // bge falls through
		store_dw(2, 'h130);
		expect_store(64'h130, 64'hffff_ffff_ffff_fffd, "bge_fall");
		link = 64'(pc_words * 4 + 4);
		jump_link(16, 12);
		store_dw(1, poison_addr);
		store_dw(1, poison_addr);
		store_dw(16, 'h138);
		expect_store(64'h138, link, "jal_link");
		alu_imm(0, 17, 0, 3);
		alu_imm(0, 18, 18, 2);    // Loop body
		alu_imm(0, 17, 17, -1);
		branch_to(1, 17, 0, -8);
		store_dw(18, 'h140);
		expect_store(64'h140, 64'd6, "loop_sum");
		alu_imm(0, 0, 0, 55);
		store_dw(0, 'h148);
		expect_store(64'h148, 64'd0, "zero_reg");
		jump_link(0, 0);          // Park here
	endtask

	task automatic check_store(core_pkg::u64 addr, core_pkg::u64 data);
		logic ok;
		ok = 1'b1;
		if (seen >= exp_addr.size()) begin
			$display("store of %h to %h came after the last expected store", data, addr);
			errors++;
		end else begin
			assert (addr == exp_addr[seen]) else begin
				$display("FAIL %0t: %s stored to %h, expected %h", $time, exp_name[seen],
					addr, exp_addr[seen]);
				ok = 1'b0;
			end
			assert (data == exp_data[seen]) else begin
				$display("FAIL %0t: %s stored %h, expected %h", $time, exp_name[seen],
					data, exp_data[seen]);
				ok = 1'b0;
			end
			$display("test %0d %s: %s", seen + 1, exp_name[seen], ok ? "ok" : "mismatch");
			if (ok)
				n_ok++;
			else
				n_bad++;
			seen++;
		end
	endtask

	// Both memories answer after 0 to 3 waiting cycles
	always @(negedge clk) begin
		iresp_data_ok = 1'b0;
		dresp_data_ok = 1'b0;
		if (ireq_valid && i_wait == 2'd0) begin
			iresp_data_ok = 1'b1;
			iresp_data = imem[ireq_addr[9:2]];
			rng = xorshift(rng);
			i_wait = rng[1:0];
		end else if (ireq_valid) begin
			i_wait = i_wait - 2'd1;
		end
		if (dreq_valid && d_wait == 2'd0) begin
			dresp_data_ok = 1'b1;
			if (dreq_write) begin
				check_store(dreq_addr, dreq_wdata);
				dmem[dreq_addr[9:3]] = dreq_wdata;
			end else begin
				dresp_rdata = dmem[dreq_addr[9:3]];
			end
			rng = xorshift(rng);
			d_wait = rng[3:2];
		end else if (dreq_valid) begin
			d_wait = d_wait - 2'd1;
		end
	end

	assert property (@(posedge clk) disable iff (rst) $rose(ireq_valid) |-> ireq_addr == 64'd0)
		else begin
			$display("FAIL %0t: first fetch from %h, expected 0", $time, ireq_addr);
			errors++;
		end

	assert property (@(posedge clk) disable iff (rst)
		ireq_valid && !iresp_data_ok |=> $stable(ireq_addr))
		else begin
			$display("FAIL %0t: fetch address moved to %h while waiting", $time, ireq_addr);
			errors++;
		end

	assert property (@(posedge clk) disable iff (rst)
		ireq_valid && iresp_data_ok |=> ireq_addr == $past(ireq_addr) + 64'd4
			|| ireq_addr == $past(ireq_addr) || jump_dst[ireq_addr[9:2]])
		else begin
			$display("FAIL %0t: fetch jumped to %h", $time, ireq_addr);
			errors++;
		end

	assert property (@(posedge clk) disable iff (rst)
		dreq_valid && !dresp_data_ok |=> dreq_valid && $stable(dreq_addr)
			&& $stable(dreq_write) && $stable(dreq_wdata))
		else begin
			$display("FAIL %0t: data request changed while waiting", $time);
			errors++;
		end

	assert property (@(posedge clk) disable iff (rst) dreq_valid |-> dreq_addr != poison_addr)
		else begin
			$display("FAIL %0t: flushed store reached the data bus", $time);
			errors++;
		end

	initial begin
		rst = 1'b1;
		iresp_data_ok = 1'b0;
		iresp_data = '0;
		dresp_data_ok = 1'b0;
		dresp_rdata = '0;
		rng = 32'hc3fb_cc0d;
		i_wait = 2'd0;
		d_wait = 2'd0;
		seen = 0;
		n_ok = 0;
		n_bad = 0;
		errors = 0;
		build_program();
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (seen < exp_addr.size() && cycles < max_cycles)
			@(posedge clk);
		if (seen < exp_addr.size()) begin
			$display("timeout after %0d cycles, %0d of %0d stores seen", cycles, seen,
				exp_addr.size());
			errors++;
		end else begin
			repeat (20) @(posedge clk);  // Room for a stray store
		end
		$display("%0d tests: %0d ok, %0d mismatched, %0d other errors", exp_addr.size(),
			n_ok, n_bad, errors);
		if (n_bad == 0 && errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule
